// ==== hdl/flashEngine.sv ====
`timescale 1ns/10ps

module flashEngine
    import flasherPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      clkEn,
    input  flashReqT  req,
    input  flashWordT flashDataIn,
    input  flashWordT imageWord,
    output flashStatT stat,
    output flashAddrT imageAddr,
    output flashAddrT flashAddr,
    output logic      imageRegion,
    output flashWordT flashData,
    output logic      instFlashEn,
    output logic      dataFlashEn,
    output logic      flashReadEn,
    output logic      systemEnable
);

    logic      active;      // A pass is running
    logic      region;      // 0 instruction, 1 data
    flashAddrT addr;
    logic      poweredUp;
    logic      firstFlash;  // Power-up flash, data pass follows the instruction pass
    logic      doneQ;

    flashAddrT nextAddr;
    logic      lastAddr;
    logic      skipWindow;
    logic      writeCycle;

    // Data region jumps over the I/O window in one step
    assign skipWindow = region && (addr == MEM_MAP_START - 10'd1);
    assign lastAddr   = (addr == flashAddrT'(IMAGE_WORDS - 1));

    always_comb begin
        if (skipWindow) begin
            nextAddr = MEM_MAP_END + 10'd1;
        end else begin
            nextAddr = addr + 10'd1;    // Wraps to zero after the last word
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            active     <= 1'b0;
            region     <= 1'b0;
            addr       <= '0;
            poweredUp  <= 1'b0;
            firstFlash <= 1'b0;
            doneQ      <= 1'b0;
        end else if (clkEn) begin
            doneQ <= 1'b0;
            if (req.startInst) begin
                active     <= 1'b1;
                region     <= 1'b0;
                addr       <= '0;
                firstFlash <= !poweredUp;
            end else if (req.startData) begin
                active     <= 1'b1;
                region     <= 1'b1;
                addr       <= '0;
                firstFlash <= 1'b0;
            end else if (active) begin
                addr <= nextAddr;
                if (lastAddr) begin
                    if (!region && firstFlash) begin
                        region <= 1'b1;     // Chain straight into the data pass
                    end else begin
                        active     <= 1'b0;
                        doneQ      <= 1'b1;
                        firstFlash <= 1'b0;
                        if (firstFlash) begin
                            poweredUp <= 1'b1;
                        end
                    end
                end
            end
        end
    end

    // One write per enabled cycle of a pass
    assign writeCycle = active && clkEn;

    assign instFlashEn = writeCycle && !region;
    assign dataFlashEn = writeCycle && region;
    assign flashReadEn = writeCycle;

    assign flashAddr   = addr;
    assign imageAddr   = addr;
    assign imageRegion = region;

    always_comb begin
        if (req.useExternal) begin
            flashData = flashDataIn;
        end else begin
            flashData = imageWord;
        end
    end

    assign systemEnable   = poweredUp;  // Rises with the final done and stays high
    assign stat.busy      = active;
    assign stat.done      = doneQ;
    assign stat.poweredUp = poweredUp;

    // The I/O window belongs to the system, never to the flasher
    assert property (@(posedge clk) disable iff (!arstN)
        dataFlashEn |-> !(flashAddr inside {[MEM_MAP_START:MEM_MAP_END]}));

    assert property (@(posedge clk) disable iff (!arstN)
        !(instFlashEn && dataFlashEn));

endmodule

// ==== hdl/flashImage.sv ====
`timescale 1ns/10ps

// Read-only copy of the built-in instruction and data images
module flashImage
    import flasherPkg::*;
(
    input  flashAddrT addr,
    input  logic      dataRegion,   // 0 selects the instruction image
    output flashWordT word
);

    flashWordT instRom [IMAGE_WORDS];
    flashWordT dataRom [IMAGE_WORDS];

    // Both tables are constant, built from the package rules
    for (genvar i = 0; i < IMAGE_WORDS; i++) begin : gRom
        assign instRom[i] = instImageWord(flashAddrT'(i));
        assign dataRom[i] = dataImageWord(flashAddrT'(i));
    end

    flashWordT instWord;
    flashWordT dataWord;

    assign instWord = instRom[addr];
    assign dataWord = dataRom[addr];

    // Region picks which table feeds the engine
    always_comb begin
        if (dataRegion) begin
            word = dataWord;
        end else begin
            word = instWord;
        end
    end

endmodule

// ==== hdl/flasherPkg.sv ====
package flasherPkg;

    // Widths with a meaning of their own
    typedef logic [9:0]  flashAddrT;    // Word address into either memory
    typedef logic [15:0] flashWordT;    // One flashed word
    typedef logic [3:0]  resetVecT;     // Software reset request vector

    // Reset vector bits, highest priority first
    localparam int RESET_FULL_BIT = 3;
    localparam int RESET_INST_BIT = 2;
    localparam int RESET_IO_BIT   = 1;
    localparam int RESET_DATA_BIT = 0;

    // Memory-mapped I/O window inside the data memory
    localparam flashAddrT MEM_MAP_START = 10'd384;  // First address of the window
    localparam flashAddrT MEM_MAP_END   = 10'd511;  // Last address of the window

    localparam int IMAGE_WORDS = 1024;  // Size of each built-in image

    typedef enum logic [1:0] {
        SEQ_IDLE       = 2'b00,
        SEQ_FLASH_INST = 2'b01,
        SEQ_FLASH_DATA = 2'b10,
        SEQ_SUBMIT     = 2'b11
    } seqStateT;

    // Sequencer to engine
    typedef struct packed {
        logic startInst;    // Pulse, start an instruction pass
        logic startData;    // Pulse, start a data pass
        logic useExternal;  // Level, write flashDataIn instead of the image
    } flashReqT;

    // Engine to sequencer
    typedef struct packed {
        logic busy;         // High while a pass runs
        logic done;         // Pulse after the last write of a pass
        logic poweredUp;    // Set once the power-up flash is complete
    } flashStatT;

    // Instruction image: address XOR a fixed pattern
    function automatic flashWordT instImageWord(input flashAddrT addr);
        flashWordT word;
        word = {6'b0, addr};
        return word ^ 16'hA5C3;
    endfunction

    // Data image: address rotated left by 3 in its own width, plus an offset
    function automatic flashWordT dataImageWord(input flashAddrT addr);
        flashAddrT rotated;
        flashWordT word;
        rotated = {addr[6:0], addr[9:7]};
        word = {6'b0, rotated};
        return word + 16'h1234;
    endfunction

endpackage

// ==== hdl/memFlasher.sv ====
`timescale 1ns/10ps

// Boot loader top: sequencer decides, engine copies, image supplies words
module memFlasher
    import flasherPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      clkEn,
    input  logic      flashInit,
    input  logic      softwareReset,
    input  resetVecT  resetVector,
    input  flashWordT flashDataIn,
    output logic      instFlashEn,
    output logic      dataFlashEn,
    output flashAddrT flashAddr,
    output flashWordT flashData,
    output logic      flashReadEn,
    output logic      systemEnable,
    output logic      resetTrigger,
    output logic      resetResponse,
    output logic      cpuResetLockout,
    output logic      ioResetLockout
);

    flashReqT  req;
    flashStatT stat;
    flashAddrT imageAddr;
    logic      imageRegion;
    flashWordT imageWord;

    resetSequencer u_resetSequencer (
        .clk            (clk),
        .arstN          (arstN),
        .clkEn          (clkEn),
        .flashInit      (flashInit),
        .softwareReset  (softwareReset),
        .resetVector    (resetVector),
        .stat           (stat),
        .req            (req),
        .resetTrigger   (resetTrigger),
        .resetResponse  (resetResponse),
        .cpuResetLockout(cpuResetLockout),
        .ioResetLockout (ioResetLockout)
    );

    flashEngine u_flashEngine (
        .clk         (clk),
        .arstN       (arstN),
        .clkEn       (clkEn),
        .req         (req),
        .flashDataIn (flashDataIn),
        .imageWord   (imageWord),
        .stat        (stat),
        .imageAddr   (imageAddr),
        .flashAddr   (flashAddr),
        .imageRegion (imageRegion),
        .flashData   (flashData),
        .instFlashEn (instFlashEn),
        .dataFlashEn (dataFlashEn),
        .flashReadEn (flashReadEn),
        .systemEnable(systemEnable)
    );

    flashImage u_flashImage (
        .addr      (imageAddr),
        .dataRegion(imageRegion),
        .word      (imageWord)
    );

endmodule

// ==== hdl/resetSequencer.sv ====
`timescale 1ns/10ps

module resetSequencer
    import flasherPkg::*;
(
    input  logic      clk,
    input  logic      arstN,
    input  logic      clkEn,
    input  logic      flashInit,
    input  logic      softwareReset,
    input  resetVecT  resetVector,
    input  flashStatT stat,
    output flashReqT  req,
    output logic      resetTrigger,
    output logic      resetResponse,
    output logic      cpuResetLockout,
    output logic      ioResetLockout
);

    seqStateT state;
    resetVecT kind;         // One-hot action in service or zero for the power-up flash
    logic     submitPhase;  // Second cycle of SEQ_SUBMIT
    logic     fullTrig;     // Full reset trigger outside SEQ_SUBMIT

    resetVecT action;
    logic     takeInit;
    logic     takeReset;
    logic     inSubmit;

    // Keep only the highest set bit of the vector
    always_comb begin
        action = '0;
        if (resetVector[RESET_FULL_BIT]) begin
            action[RESET_FULL_BIT] = 1'b1;
        end else if (resetVector[RESET_INST_BIT]) begin
            action[RESET_INST_BIT] = 1'b1;
        end else if (resetVector[RESET_IO_BIT]) begin
            action[RESET_IO_BIT] = 1'b1;
        end else if (resetVector[RESET_DATA_BIT]) begin
            action[RESET_DATA_BIT] = 1'b1;
        end
    end

    // Init only before power-up and software resets only after it
    assign takeInit  = clkEn && (state == SEQ_IDLE) && flashInit && !stat.poweredUp;
    assign takeReset = clkEn && (state == SEQ_IDLE) && softwareReset && stat.poweredUp
                       && (|resetVector);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state       <= SEQ_IDLE;
            kind        <= '0;
            submitPhase <= 1'b0;
            fullTrig    <= 1'b0;
        end else if (clkEn) begin
            fullTrig <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (takeInit) begin
                        kind  <= '0;
                        state <= SEQ_FLASH_INST;
                    end else if (takeReset) begin
                        kind <= action;
                        if (action[RESET_FULL_BIT]) begin
                            fullTrig <= 1'b1;   // No flash and no reply
                        end else if (action[RESET_INST_BIT]) begin
                            state <= SEQ_FLASH_INST;
                        end else if (action[RESET_IO_BIT]) begin
                            state <= SEQ_SUBMIT;
                        end else begin
                            state <= SEQ_FLASH_DATA;
                        end
                    end
                end
                SEQ_FLASH_INST: begin
                    // Power-up flash covers both memories before this done
                    if (stat.done) begin
                        state <= kind[RESET_INST_BIT] ? SEQ_SUBMIT : SEQ_IDLE;
                    end
                end
                SEQ_FLASH_DATA: begin
                    if (stat.done) begin
                        state <= SEQ_IDLE;
                    end
                end
                SEQ_SUBMIT: begin
                    submitPhase <= !submitPhase;
                    if (submitPhase) begin
                        state <= SEQ_IDLE;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign inSubmit = (state == SEQ_SUBMIT);

    assign req.startInst   = takeInit || (takeReset && action[RESET_INST_BIT]);
    assign req.startData   = takeReset && action[RESET_DATA_BIT];
    assign req.useExternal = (state == SEQ_FLASH_DATA);    // Only a data re-flash

    assign resetTrigger  = fullTrig || (inSubmit && !submitPhase);
    assign resetResponse = (inSubmit && submitPhase && kind[RESET_IO_BIT])
                           || ((state == SEQ_FLASH_DATA) && stat.done);

    assign cpuResetLockout = inSubmit && !kind[RESET_INST_BIT];
    assign ioResetLockout  = inSubmit && !kind[RESET_IO_BIT];

    assert property (@(posedge clk) disable iff (!arstN)
        $onehot0({req.startInst, req.startData}));

    assert property (@(posedge clk) disable iff (!arstN)
        !(resetResponse && resetTrigger));

endmodule

// ==== memFlasher.f ====
hdl/flasherPkg.sv
hdl/flashImage.sv
hdl/resetSequencer.sv
hdl/flashEngine.sv
hdl/memFlasher.sv
tb/memFlasherTb.sv

// ==== tb/memFlasherTb.sv ====
`timescale 1ns/10ps

module memFlasherTb
    import flasherPkg::*;
();

    localparam int NUM_TESTS       = 6;
    localparam int WATCHDOG_CYCLES = 5000 * NUM_TESTS;
    localparam int WAIT_ENABLE     = 0;
    localparam int WAIT_TRIG       = 1;
    localparam int WAIT_RESP       = 2;

    logic      clk;
    logic      arstN;
    logic      clkEn;
    logic      flashInit;
    logic      softwareReset;
    resetVecT  resetVector;
    flashWordT flashDataIn;
    logic      instFlashEn;
    logic      dataFlashEn;
    flashAddrT flashAddr;
    flashWordT flashData;
    logic      flashReadEn;
    logic      systemEnable;
    logic      resetTrigger;
    logic      resetResponse;
    logic      cpuResetLockout;
    logic      ioResetLockout;

    // Shadow copies of the two target memories
    flashWordT instShadow [IMAGE_WORDS];
    flashWordT dataShadow [IMAGE_WORDS];
    logic      instWritten [IMAGE_WORDS];
    logic      dataWritten [IMAGE_WORDS];

    flashAddrT expInstAddr;
    flashAddrT expDataAddr;
    logic      expectExternal;  // Data words come from flashDataIn
    logic      enablePrev;
    logic      cpuLockSeen;
    logic      ioLockSeen;
    logic [31:0] lfsr;
    int instCount, dataCount, trigCount, respCount, gatedCycles;
    int cycleCount, lastWriteCycle, firstWriteCycle, trigCycle, respCycle;
    int reqCycle, initCycle, enableCycle;
    int errorCount, errStart, passCount, failCount;

    memFlasher u_memFlasher (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Expected image contents, written straight from the boot image rules
    function automatic flashWordT expectedInstWord(input int a);
        return 16'(a) ^ 16'hA5C3;
    endfunction

    function automatic flashWordT expectedDataWord(input int a);
        int r;
        r = ((a << 3) | (a >> 7)) & 'h3FF;  // 10-bit rotate left by 3
        return 16'(r + 'h1234);
    endfunction

    function automatic logic [31:0] stepLfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic takeBits(input int n, output logic [15:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = stepLfsr(lfsr);
            value = {value[14:0], lfsr[0]};
        end
    endtask

    task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                              input string msg);
        if (actual !== expected) begin
            errorCount++;
            $display("error at %0t ns: %s (got %0h, expected %0h)", $time, msg, actual, expected);
        end
    endtask

    task automatic reportTimeout(input string what);
        errorCount++;
        $display("timeout at %0t ns: %s did not happen in time", $time, what);
    endtask

    task automatic startTest();
        errStart = errorCount;
    endtask

    task automatic finishTest(input string name);
        int errs;
        errs = errorCount - errStart;
        if (errs == 0) begin
            passCount++;
            $display("test %s passed", name);
        end else begin
            failCount++;
            $display("test %s failed with %0d errors", name, errs);
        end
    endtask

    task automatic clearTracking();
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            instWritten[i] = 1'b0;
            dataWritten[i] = 1'b0;
        end
        expInstAddr = '0;
        expDataAddr = '0;
        instCount = 0;
        dataCount = 0;
        trigCount = 0;
        respCount = 0;
        gatedCycles = 0;
        lastWriteCycle = -1;
        firstWriteCycle = -1;
        trigCycle = -1;
        respCycle = -1;
        reqCycle = -1;
        initCycle = -1;
        enableCycle = -1;
        cpuLockSeen = 1'b0;
        ioLockSeen = 1'b0;
    endtask

    task automatic applyReset();
        @(posedge clk);
        arstN         <= 1'b0;
        clkEn         <= 1'b1;
        flashInit     <= 1'b0;
        softwareReset <= 1'b0;
        resetVector   <= '0;
        flashDataIn   <= '0;
        repeat (8) @(posedge clk);
        arstN <= 1'b1;
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic pulseInit();
        @(posedge clk);
        flashInit <= 1'b1;
        @(posedge clk);
        flashInit <= 1'b0;
    endtask

    task automatic issueReset(input resetVecT vec);
        @(posedge clk);
        softwareReset <= 1'b1;
        resetVector   <= vec;
        @(posedge clk);
        softwareReset <= 1'b0;
        resetVector   <= '0;
    endtask

    // Polls monitor state on the rising edge, set on the previous falling edge
    task automatic waitFor(input int what, input int maxCycles, input string label);
        int  cycles;
        logic met;
        met = 1'b0;
        cycles = 0;
        while (!met && cycles < maxCycles) begin
            @(posedge clk);
            cycles++;
            case (what)
                WAIT_ENABLE: met = (enableCycle >= 0);
                WAIT_TRIG:   met = (trigCount > 0);
                WAIT_RESP:   met = (respCount > 0);
                default:     met = 1'b1;
            endcase
        end
        if (!met) reportTimeout(label);
    endtask

    function automatic int instMismatches();
        int bad;
        bad = 0;
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            if (!instWritten[i] || instShadow[i] !== expectedInstWord(i)) bad++;
        end
        return bad;
    endfunction

    task automatic verifyPowerUp();
        int bad;
        bad = 0;
        for (int i = 0; i < IMAGE_WORDS; i++) begin
            if (i >= MEM_MAP_START && i <= MEM_MAP_END) begin
                if (dataWritten[i]) bad++;  // Window must stay untouched
            end else if (!dataWritten[i] || dataShadow[i] !== expectedDataWord(i)) begin
                bad++;
            end
        end
        checkEqual(instCount, 1024, "instruction write count");
        checkEqual(dataCount, 896, "data write count");
        checkEqual(instMismatches(), 0, "instruction shadow mismatches");
        checkEqual(bad, 0, "data shadow mismatches");
        checkEqual(enableCycle, lastWriteCycle + 1, "systemEnable rise after last write");
        checkEqual(trigCount + respCount, 0, "pulses during power-up flash");
    endtask

    // Watches every cycle at the falling edge, where outputs are settled
    always @(negedge clk) begin
        cycleCount++;
        if (arstN) begin
            if (!clkEn) begin
                gatedCycles++;
                checkEqual(instFlashEn | dataFlashEn, 0, "write strobe while clkEn low");
            end
            checkEqual(flashReadEn, instFlashEn | dataFlashEn, "flashReadEn against strobes");
            if (instFlashEn) begin
                checkEqual(flashAddr, expInstAddr, "instruction write address");
                checkEqual(flashData, expectedInstWord(flashAddr), "instruction word");
                instShadow[flashAddr]  = flashData;
                instWritten[flashAddr] = 1'b1;
                expInstAddr = expInstAddr + 10'd1;
                instCount++;
                lastWriteCycle = cycleCount;
                if (firstWriteCycle < 0) firstWriteCycle = cycleCount;
            end
            if (dataFlashEn) begin
                checkEqual(flashAddr >= MEM_MAP_START && flashAddr <= MEM_MAP_END, 0,
                           "data write inside the I/O window");
                checkEqual(flashAddr, expDataAddr, "data write address");
                checkEqual(flashData, expectExternal ? flashDataIn : expectedDataWord(flashAddr),
                           "data word");
                dataShadow[flashAddr]  = flashData;
                dataWritten[flashAddr] = 1'b1;
                expDataAddr = (expDataAddr == 10'd383) ? 10'd512 : expDataAddr + 10'd1;
                dataCount++;
                lastWriteCycle = cycleCount;
                if (firstWriteCycle < 0) firstWriteCycle = cycleCount;
            end
            if (clkEn && resetTrigger) begin
                trigCount++;
                trigCycle = cycleCount;
            end
            if (clkEn && resetResponse) begin
                respCount++;
                respCycle = cycleCount;
            end
            if (cpuResetLockout) cpuLockSeen = 1'b1;
            if (ioResetLockout) ioLockSeen = 1'b1;
            if (clkEn && softwareReset) reqCycle = cycleCount;
            if (clkEn && flashInit) initCycle = cycleCount;
            if (systemEnable && !enablePrev) enableCycle = cycleCount;
        end
        enablePrev = systemEnable;
    end

    task automatic runInstReset(input resetVecT vec);
        clearTracking();
        issueReset(vec);
        waitFor(WAIT_TRIG, 2000, "trigger after instruction re-flash");
        idle(10);
        checkEqual(instCount, 1024, "instruction re-flash write count");
        checkEqual(dataCount, 0, "data writes during instruction reset");
        checkEqual(instMismatches(), 0, "instruction re-flash mismatches");
        checkEqual(firstWriteCycle, reqCycle + 1, "instruction re-flash start latency");
        checkEqual(trigCycle, lastWriteCycle + 2, "trigger latency after re-flash");
        checkEqual(trigCount, 1, "trigger count for instruction reset");
        checkEqual(respCount, 0, "response count for instruction reset");
        checkEqual(cpuLockSeen, 0, "cpuResetLockout for instruction reset");
        checkEqual(ioLockSeen, 1, "ioResetLockout for instruction reset");
    endtask

    task automatic runIoReset(input resetVecT vec);
        clearTracking();
        issueReset(vec);
        waitFor(WAIT_RESP, 100, "response to IO reset");
        idle(10);
        checkEqual(instCount + dataCount, 0, "writes during IO reset");
        checkEqual(trigCount, 1, "trigger count for IO reset");
        checkEqual(respCount, 1, "response count for IO reset");
        checkEqual(trigCycle, reqCycle + 1, "IO trigger latency");
        checkEqual(respCycle, trigCycle + 1, "IO response latency");
        checkEqual(cpuLockSeen, 1, "cpuResetLockout for IO reset");
        checkEqual(ioLockSeen, 0, "ioResetLockout for IO reset");
    endtask

    task automatic runFullReset(input resetVecT vec);
        clearTracking();
        issueReset(vec);
        waitFor(WAIT_TRIG, 100, "trigger for full reset");
        idle(10);
        checkEqual(instCount + dataCount, 0, "writes during full reset");
        checkEqual(trigCount, 1, "trigger count for full reset");
        checkEqual(respCount, 0, "response count for full reset");
        checkEqual(trigCycle, reqCycle + 1, "full reset trigger latency");
        checkEqual(cpuLockSeen | ioLockSeen, 0, "lockouts during full reset");
    endtask

    task automatic testAfterReset();
        startTest();
        applyReset();
        clearTracking();
        @(negedge clk);
        checkEqual({instFlashEn, dataFlashEn, flashReadEn, systemEnable, resetTrigger,
                    resetResponse, cpuResetLockout, ioResetLockout}, 0, "outputs after reset");
        issueReset(4'b1111);    // Ignored before power-up
        idle(20);
        checkEqual(instCount + dataCount, 0, "writes from early software reset");
        checkEqual(trigCount + respCount, 0, "pulses from early software reset");
        checkEqual(enableCycle, -1, "systemEnable before power-up");
        finishTest("after reset");
    endtask

    task automatic testPowerUp();
        startTest();
        clearTracking();
        expectExternal = 1'b0;
        pulseInit();
        waitFor(WAIT_ENABLE, 2500, "systemEnable after power-up flash");
        idle(5);
        verifyPowerUp();
        checkEqual(firstWriteCycle, initCycle + 1, "power-up flash start latency");
        finishTest("power-up flash");
    endtask

    task automatic testClkEnGating();
        logic [15:0] bits;
        startTest();
        applyReset();
        clearTracking();
        pulseInit();
        for (int c = 0; c < 6000 && enableCycle < 0; c++) begin
            @(posedge clk);
            takeBits(1, bits);
            clkEn <= bits[0];
        end
        if (enableCycle < 0) reportTimeout("systemEnable under clkEn gating");
        @(posedge clk);
        clkEn <= 1'b1;
        idle(5);
        verifyPowerUp();
        checkEqual(gatedCycles > 0, 1, "clkEn low cycles during gated flash");
        finishTest("clkEn gating");
    endtask

    task automatic testDataReset();
        logic [15:0] word;
        startTest();
        clearTracking();
        expectExternal = 1'b1;
        issueReset(4'b0001);
        for (int c = 0; c < 2000 && respCount == 0; c++) begin
            @(posedge clk);
            takeBits(16, word);
            flashDataIn <= word;
        end
        if (respCount == 0) reportTimeout("response to data reset");
        idle(10);
        expectExternal = 1'b0;
        checkEqual(dataCount, 896, "data re-flash write count");
        checkEqual(instCount, 0, "instruction writes during data reset");
        checkEqual(firstWriteCycle, reqCycle + 1, "data re-flash start latency");
        checkEqual(respCycle, lastWriteCycle + 1, "data reset response latency");
        checkEqual(respCount, 1, "response count for data reset");
        checkEqual(trigCount, 0, "trigger count for data reset");
        finishTest("data reset");
    endtask

    task automatic testInstIoReset();
        startTest();
        runInstReset(4'b0100);
        runIoReset(4'b0010);
        finishTest("inst and io resets");
    endtask

    task automatic testPriorityFull();
        startTest();
        runFullReset(4'b1011);  // Full wins over the lower bits
        runInstReset(4'b0101);
        runIoReset(4'b0011);
        runFullReset(4'b1000);
        finishTest("priority and full reset");
    endtask

    initial begin
        arstN = 1'b0;
        clkEn = 1'b0;
        flashInit = 1'b0;
        softwareReset = 1'b0;
        resetVector = '0;
        flashDataIn = '0;
        lfsr = 32'h136e_5562;
        expectExternal = 1'b0;
        enablePrev = 1'b0;
        cycleCount = 0;
        errorCount = 0;
        passCount = 0;
        failCount = 0;
        clearTracking();
        testAfterReset();
        testPowerUp();
        testClkEnGating();
        testDataReset();
        testInstIoReset();
        testPriorityFull();
        $display("summary: %0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule
